//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // register file index width, 32 integer registers
    localparam int REG_W = 5;

    // x0 reads as zero and ignores writes
    localparam logic [REG_W-1:0] REG_ZERO = '0;

    // decoded instruction class as the ID stage reports it
    // four bits to match the decoder's class field
    typedef enum logic [3:0] {
        // empty slot or explicit nop
        IR_NOP    = 4'h0,
        // register-register arithmetic and logic
        IR_ALU    = 4'h1,
        // register-immediate arithmetic and logic
        IR_IMM    = 4'h2,
        // lb, lh, lw, lbu, lhu
        IR_LOAD   = 4'h3,
        // sb, sh, sw
        IR_STORE  = 4'h4,
        // conditional branches, reads rs1 and rs2
        IR_BRANCH = 4'h5,
        // jal and jalr, writes the link register
        IR_JUMP   = 4'h6,
        // lui and auipc, no register sources
        IR_LUI    = 4'h7
    } ir_type_t;

    // loads deliver data one stage later than ALU results
    // which is the root of the load-use hazard
    // stores read rs2 only as write data, so that operand
    // is needed later than rs1, the address base

endpackage

//--- src/hazard_pkg.sv
package hazard_pkg;

    import rv_isa_pkg::*;

    // bypass source for one ID operand
    typedef enum logic [1:0] {
        // no newer producer in flight, read the register file
        FWD_RF        = 2'd0,
        // ALU result of the instruction now in EX
        FWD_EX        = 2'd1,
        // result of the instruction now in MEM
        FWD_MEM       = 2'd2,
        // store data picked up from the load's MEM stage next cycle
        FWD_LOAD_LATE = 2'd3
    } fwd_sel_t;

    // shadow record of one pipeline stage
    // EX and MEM carry the same fields here, a wider MEM record
    // can extend this struct and reuse stage_reg as is
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic             wr_reg_n;
        ir_type_t         ir_type;
    } stage_t;

    // empty stage, never matches and never writes
    localparam stage_t BUBBLE = '{
        valid:    1'b0,
        rd:       REG_ZERO,
        wr_reg_n: 1'b1,
        ir_type:  IR_NOP
    };

endpackage

//--- src/stage_if.sv
`timescale 1ns/1ps

// view of one pipeline stage's write-back fields
interface stage_if;

    import rv_isa_pkg::*;

    // stage holds a live instruction
    logic             valid;
    // destination register index
    logic [REG_W-1:0] rd;
    // active low, instruction writes rd
    logic             wr_reg_n;
    // class of the instruction, used to spot loads
    ir_type_t         ir_type;

    // driven by the stage register side of the top
    modport producer (
        output valid,
        output rd,
        output wr_reg_n,
        output ir_type
    );

    // hazard logic only looks at the stage
    modport observer (
        input valid,
        input rd,
        input wr_reg_n,
        input ir_type
    );

endinterface

//--- src/stage_reg.sv
`timescale 1ns/1ps

// one pipeline stage register
// loads the incoming record each cycle, or a bubble on request
module stage_reg #(
    parameter type payload_t = hazard_pkg::stage_t
) (
    input  logic     clk,
    input  logic     rst_n,
    // replace the incoming record with bubble_val this edge
    input  logic     bubble,
    // record from the stage before
    input  payload_t d,
    // empty-stage value, also the reset value
    input  payload_t bubble_val,
    // record held by this stage
    output payload_t q
);

    // next-state select
    payload_t q_next;

    always_comb begin
        // a stalled consumer stays in ID, so the stage after it
        // must see an empty slot instead of a copy
        if (bubble) begin
            q_next = bubble_val;
        end else begin
            q_next = d;
        end
    end

    // bubble_val is a constant at every instance, so the reset
    // value folds to fixed set and clear bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= bubble_val;
        end else begin
            q <= q_next;
        end
    end

    // whole record moves together, there is no partial update
    // and no enable besides the bubble request

    // q feeds both the next stage and the hazard logic
    // the top copies it onto the stage interface

endmodule

//--- src/stall_detector.sv
`timescale 1ns/1ps

// load-use stall decision for the instruction in ID
module stall_detector (
    input  logic                         id_valid,
    input  rv_isa_pkg::ir_type_t         id_ir_type,
    input  logic [rv_isa_pkg::REG_W-1:0] rs1,
    input  logic [rv_isa_pkg::REG_W-1:0] rs2,
    stage_if.observer                    ex,
    output logic                         stall
);

    import rv_isa_pkg::*;

    // EX will write a register
    logic ex_writes;
    // class checks
    logic ex_is_load;
    logic id_is_store;
    // source matches the EX destination
    logic rs1_updated;
    logic rs2_updated;
    // same, but x0 never counts
    logic rs1_hit;
    logic rs2_hit;

    assign ex_writes   = ex.valid && !ex.wr_reg_n;
    assign ex_is_load  = (ex.ir_type == IR_LOAD);
    assign id_is_store = (id_ir_type == IR_STORE);

    assign rs1_updated = ex_writes && (rs1 == ex.rd);
    assign rs2_updated = ex_writes && (rs2 == ex.rd);

    // a load targeting x0 writes nothing a consumer can see
    assign rs1_hit = rs1_updated && (rs1 != REG_ZERO);
    assign rs2_hit = rs2_updated && (rs2 != REG_ZERO);

    always_comb begin
        if (!id_valid || (!rs1_updated && !rs2_updated)) begin
            // empty ID slot or no dependency on EX
            stall = 1'b0;
        end else if (ex_is_load && id_is_store) begin
            // store data (rs2) can take the load result late from MEM,
            // the address base (rs1) is needed in EX and cannot
            stall = rs1_hit;
        end else if (ex_is_load) begin
            // any other consumer needs the value in EX
            stall = rs1_hit || rs2_hit;
        end else begin
            // ALU producers in EX are covered by the bypass network
            stall = 1'b0;
        end
    end

endmodule

//--- src/forward_unit.sv
`timescale 1ns/1ps

// bypass source per ID operand
module forward_unit (
    input  logic                         id_valid,
    input  rv_isa_pkg::ir_type_t         id_ir_type,
    input  logic [rv_isa_pkg::REG_W-1:0] rs1,
    input  logic [rv_isa_pkg::REG_W-1:0] rs2,
    stage_if.observer                    ex,
    stage_if.observer                    mem,
    output hazard_pkg::fwd_sel_t         fwd_rs1_sel,
    output hazard_pkg::fwd_sel_t         fwd_rs2_sel
);

    import rv_isa_pkg::*;
    import hazard_pkg::*;

    // stage write enables
    logic ex_wr;
    logic mem_wr;
    logic ex_load;
    logic id_store;
    // operand is worth bypassing at all
    logic rs1_live;
    logic rs2_live;

    // priority pick for one operand
    function automatic fwd_sel_t pick_src(
        input logic live,
        input logic ex_hit,
        input logic mem_hit,
        input logic ex_is_load,
        input logic late_ok
    );
        fwd_sel_t sel;
        sel = FWD_RF;
        if (live && ex_hit) begin
            // EX is the newest producer, it shadows MEM
            if (!ex_is_load) begin
                sel = FWD_EX;
            end else if (late_ok) begin
                sel = FWD_LOAD_LATE;
            end
            // load feeding any other operand leaves FWD_RF, stall covers it
        end else if (live && mem_hit) begin
            sel = FWD_MEM;
        end
        return sel;
    endfunction

    assign ex_wr    = ex.valid && !ex.wr_reg_n;
    assign mem_wr   = mem.valid && !mem.wr_reg_n;
    assign ex_load  = (ex.ir_type == IR_LOAD);
    assign id_store = (id_ir_type == IR_STORE);

    // x0 always reads zero, and an empty ID slot needs nothing
    assign rs1_live = id_valid && (rs1 != REG_ZERO);
    assign rs2_live = id_valid && (rs2 != REG_ZERO);

    // only store data may wait for the late load path
    assign fwd_rs1_sel = pick_src(rs1_live, ex_wr && (ex.rd == rs1),
                                  mem_wr && (mem.rd == rs1), ex_load, 1'b0);
    assign fwd_rs2_sel = pick_src(rs2_live, ex_wr && (ex.rd == rs2),
                                  mem_wr && (mem.rd == rs2), ex_load, id_store);

endmodule

//--- src/hazard_top.sv
`timescale 1ns/1ps

// hazard control for the five-stage integer pipeline
module hazard_top (
    input  logic                         clk,
    input  logic                         rst_n,
    // decoded fields of the instruction in ID
    input  logic                         id_valid,
    input  rv_isa_pkg::ir_type_t         id_ir_type,
    input  logic [rv_isa_pkg::REG_W-1:0] id_rs1,
    input  logic [rv_isa_pkg::REG_W-1:0] id_rs2,
    input  logic [rv_isa_pkg::REG_W-1:0] id_rd,
    input  logic                         id_wr_reg_n,
    // hold ID and insert a bubble into EX
    output logic                         stall,
    output hazard_pkg::fwd_sel_t         fwd_rs1_sel,
    output hazard_pkg::fwd_sel_t         fwd_rs2_sel
);

    import hazard_pkg::*;

    // ID record, EX and MEM shadow records
    stage_t id_rec;
    stage_t ex_q;
    stage_t mem_q;

    stage_if ex_bus ();
    stage_if mem_bus ();

    // pack the ID fields as the EX stage will hold them
    assign id_rec = '{
        valid:    id_valid,
        rd:       id_rd,
        wr_reg_n: id_wr_reg_n,
        ir_type:  id_ir_type
    };

    // EX register takes a bubble while ID is stalled
    stage_reg #(.payload_t(stage_t)) ex_reg (
        .clk(clk), .rst_n(rst_n), .bubble(stall),
        .d(id_rec), .bubble_val(BUBBLE), .q(ex_q)
    );

    // MEM just follows EX, nothing stalls it here
    stage_reg #(.payload_t(stage_t)) mem_reg (
        .clk(clk), .rst_n(rst_n), .bubble(1'b0),
        .d(ex_q), .bubble_val(BUBBLE), .q(mem_q)
    );

    // stage registers are the producers of both buses
    assign ex_bus.valid     = ex_q.valid;
    assign ex_bus.rd        = ex_q.rd;
    assign ex_bus.wr_reg_n  = ex_q.wr_reg_n;
    assign ex_bus.ir_type   = ex_q.ir_type;
    assign mem_bus.valid    = mem_q.valid;
    assign mem_bus.rd       = mem_q.rd;
    assign mem_bus.wr_reg_n = mem_q.wr_reg_n;
    assign mem_bus.ir_type  = mem_q.ir_type;

    stall_detector stall_det (
        .id_valid(id_valid), .id_ir_type(id_ir_type),
        .rs1(id_rs1), .rs2(id_rs2), .ex(ex_bus.observer), .stall(stall)
    );

    forward_unit fwd_unit (
        .id_valid(id_valid), .id_ir_type(id_ir_type),
        .rs1(id_rs1), .rs2(id_rs2),
        .ex(ex_bus.observer), .mem(mem_bus.observer),
        .fwd_rs1_sel(fwd_rs1_sel), .fwd_rs2_sel(fwd_rs2_sel)
    );

endmodule

//--- bench/hazard_sva.sv
`timescale 1ns/1ps

// protocol properties of the hazard block, bound into hazard_top
module hazard_sva (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         id_valid,
    input rv_isa_pkg::ir_type_t         id_ir_type,
    input logic [rv_isa_pkg::REG_W-1:0] id_rs1,
    input logic [rv_isa_pkg::REG_W-1:0] id_rs2,
    input logic [rv_isa_pkg::REG_W-1:0] id_rd,
    input logic                         id_wr_reg_n,
    input logic                         stall,
    input hazard_pkg::fwd_sel_t         fwd_rs1_sel,
    input hazard_pkg::fwd_sel_t         fwd_rs2_sel,
    input hazard_pkg::stage_t           ex_q
);

    import rv_isa_pkg::*;
    import hazard_pkg::*;

    // number of property failures so far
    int fail_cnt = 0;

    // only a live load in EX may stall
    stall_needs_load: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> (ex_q.valid && ex_q.ir_type == IR_LOAD))
        else begin
            $error("stall raised without a load in EX");
            fail_cnt++;
        end

    // EX holds a bubble after a stall, so the held instruction goes through
    stall_once: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(stall) && $stable(id_valid) && $stable(id_ir_type) && $stable(id_rs1)
         && $stable(id_rs2) && $stable(id_rd) && $stable(id_wr_reg_n)) |-> !stall)
        else begin
            $error("stall held for a second cycle on the same instruction");
            fail_cnt++;
        end

    // x0 is never bypassed
    rs1_zero_rf: assert property (@(posedge clk) disable iff (!rst_n)
        (id_rs1 == REG_ZERO) |-> (fwd_rs1_sel == FWD_RF))
        else begin
            $error("rs1 is x0 but a bypass was selected");
            fail_cnt++;
        end

    rs2_zero_rf: assert property (@(posedge clk) disable iff (!rst_n)
        (id_rs2 == REG_ZERO) |-> (fwd_rs2_sel == FWD_RF))
        else begin
            $error("rs2 is x0 but a bypass was selected");
            fail_cnt++;
        end

endmodule

bind hazard_top hazard_sva sva0 (
    .clk(clk), .rst_n(rst_n), .id_valid(id_valid), .id_ir_type(id_ir_type),
    .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd), .id_wr_reg_n(id_wr_reg_n),
    .stall(stall), .fwd_rs1_sel(fwd_rs1_sel), .fwd_rs2_sel(fwd_rs2_sel), .ex_q(ex_q)
);

//--- bench/hazard_tb.sv
`timescale 1ns/1ps

// table-driven testbench for the hazard control block
module hazard_tb;

    import rv_isa_pkg::*;
    import hazard_pkg::*;

    localparam int N_TESTS = 23;
    localparam int CLK_NS = 4;
    // run limit from the table length plus margin for reset
    localparam int WATCHDOG_NS = (N_TESTS + 20) * CLK_NS;

    logic             clk;
    logic             rst_n;
    logic             id_valid;
    ir_type_t         id_ir_type;
    logic [REG_W-1:0] id_rs1;
    logic [REG_W-1:0] id_rs2;
    logic [REG_W-1:0] id_rd;
    logic             id_wr_reg_n;
    logic             stall;
    fwd_sel_t         fwd_rs1_sel;
    fwd_sel_t         fwd_rs2_sel;

    // stimulus and expected responses, one entry per cycle
    string            t_name [N_TESTS];
    logic             t_valid [N_TESTS];
    ir_type_t         t_type [N_TESTS];
    logic [REG_W-1:0] t_rs1 [N_TESTS];
    logic [REG_W-1:0] t_rs2 [N_TESTS];
    logic [REG_W-1:0] t_rd [N_TESTS];
    logic             t_wr_n [N_TESTS];
    logic             t_stall [N_TESTS];
    fwd_sel_t         t_sel1 [N_TESTS];
    fwd_sel_t         t_sel2 [N_TESTS];

    int err_stall;
    int err_sel;

    hazard_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .id_valid(id_valid), .id_ir_type(id_ir_type),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd), .id_wr_reg_n(id_wr_reg_n),
        .stall(stall), .fwd_rs1_sel(fwd_rs1_sel), .fwd_rs2_sel(fwd_rs2_sel)
    );

    task automatic set_entry(input int idx, input string name, input logic v,
                             input ir_type_t ty, input logic [REG_W-1:0] r1,
                             input logic [REG_W-1:0] r2, input logic [REG_W-1:0] rd,
                             input logic wn, input logic st,
                             input fwd_sel_t s1, input fwd_sel_t s2);
        t_name[idx]  = name;
        t_valid[idx] = v;
        t_type[idx]  = ty;
        t_rs1[idx]   = r1;
        t_rs2[idx]   = r2;
        t_rd[idx]    = rd;
        t_wr_n[idx]  = wn;
        t_stall[idx] = st;
        t_sel1[idx]  = s1;
        t_sel2[idx]  = s2;
    endtask

    // expected values follow the EX and MEM contents entry by entry
    task automatic fill_table();
        // stages empty right after reset
        set_entry(0, "after_reset", 1, IR_ALU, 5, 6, 7, 0, 0, FWD_RF, FWD_RF);
        // load-use on an ALU consumer, one stall then MEM bypass
        set_entry(1, "load_x5", 1, IR_LOAD, 1, 0, 5, 0, 0, FWD_RF, FWD_RF);
        set_entry(2, "alu_use_x5_stall", 1, IR_ALU, 5, 2, 8, 0, 1, FWD_RF, FWD_RF);
        set_entry(3, "alu_use_x5_retry", 1, IR_ALU, 5, 2, 8, 0, 0, FWD_MEM, FWD_RF);
        // store data takes the late path, rs1 from the older ALU op in MEM
        set_entry(4, "load_x6", 1, IR_LOAD, 1, 0, 6, 0, 0, FWD_RF, FWD_RF);
        set_entry(5, "store_rs2_late", 1, IR_STORE, 8, 6, 0, 1, 0, FWD_MEM, FWD_LOAD_LATE);
        // store address base on a load must stall
        set_entry(6, "load_x9", 1, IR_LOAD, 2, 0, 9, 0, 0, FWD_RF, FWD_RF);
        set_entry(7, "store_rs1_stall", 1, IR_STORE, 9, 3, 0, 1, 1, FWD_RF, FWD_RF);
        set_entry(8, "store_rs1_retry", 1, IR_STORE, 9, 3, 0, 1, 0, FWD_MEM, FWD_RF);
        // x0 is never a dependency
        set_entry(9, "load_x0", 1, IR_LOAD, 1, 0, 0, 0, 0, FWD_RF, FWD_RF);
        set_entry(10, "use_x0", 1, IR_ALU, 0, 0, 10, 0, 0, FWD_RF, FWD_RF);
        // two writers of x11, the newer one in EX must win
        set_entry(11, "alu_x11_first", 1, IR_ALU, 3, 4, 11, 0, 0, FWD_RF, FWD_RF);
        set_entry(12, "alu_x11_second", 1, IR_ALU, 3, 4, 11, 0, 0, FWD_RF, FWD_RF);
        set_entry(13, "use_x11_newest", 1, IR_ALU, 11, 0, 12, 0, 0, FWD_EX, FWD_RF);
        set_entry(14, "use_x11_two_back", 1, IR_ALU, 2, 11, 13, 0, 0, FWD_RF, FWD_MEM);
        // producers that do not write
        set_entry(15, "load_no_write", 1, IR_LOAD, 1, 0, 14, 1, 0, FWD_RF, FWD_RF);
        set_entry(16, "use_x14_no_write", 1, IR_ALU, 14, 0, 15, 1, 0, FWD_RF, FWD_RF);
        // x15 in EX and x14 in MEM, neither writes
        set_entry(17, "use_x15_no_write", 1, IR_ALU, 14, 15, 13, 0, 0, FWD_RF, FWD_RF);
        // producers in an empty ID slot
        set_entry(18, "load_invalid", 0, IR_LOAD, 1, 0, 16, 0, 0, FWD_RF, FWD_RF);
        set_entry(19, "use_x16_invalid", 1, IR_ALU, 16, 0, 17, 0, 0, FWD_RF, FWD_RF);
        set_entry(20, "use_x16_from_mem", 1, IR_LOAD, 16, 0, 18, 0, 0, FWD_RF, FWD_RF);
        // empty ID slot matches x17 in MEM and the load in EX yet needs nothing
        set_entry(21, "idle_consumer", 0, IR_ALU, 17, 18, 19, 0, 0, FWD_RF, FWD_RF);
        // invalid ALU writer of x19 now in EX
        set_entry(22, "use_x19_invalid", 1, IR_ALU, 19, 0, 20, 0, 0, FWD_RF, FWD_RF);
    endtask

    task automatic check_entry(input int idx);
        assert (stall === t_stall[idx]) else begin
            $display("** Error: %s stall expected %0b actual %0b",
                     t_name[idx], t_stall[idx], stall);
            err_stall++;
        end
        assert (fwd_rs1_sel === t_sel1[idx]) else begin
            $display("** Error: %s fwd_rs1_sel expected %0d actual %0d",
                     t_name[idx], t_sel1[idx], fwd_rs1_sel);
            err_sel++;
        end
        assert (fwd_rs2_sel === t_sel2[idx]) else begin
            $display("** Error: %s fwd_rs2_sel expected %0d actual %0d",
                     t_name[idx], t_sel2[idx], fwd_rs2_sel);
            err_sel++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the table was applied");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        // idle ID slot during reset
        rst_n       = 1'b0;
        id_valid    = 1'b0;
        id_ir_type  = IR_NOP;
        id_rs1      = '0;
        id_rs2      = '0;
        id_rd       = '0;
        id_wr_reg_n = 1'b1;
        err_stall   = 0;
        err_sel     = 0;
        fill_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            @(negedge clk);
            id_valid    = t_valid[i];
            id_ir_type  = t_type[i];
            id_rs1      = t_rs1[i];
            id_rs2      = t_rs2[i];
            id_rd       = t_rd[i];
            id_wr_reg_n = t_wr_n[i];
            // outputs are combinational, settled well before the rising edge
            #1;
            check_entry(i);
        end
        @(negedge clk);
        $display("errors: stall %0d, select %0d, assertion %0d",
                 err_stall, err_sel, dut0.sva0.fail_cnt);
        if (err_stall + err_sel + dut0.sva0.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
src/rv_isa_pkg.sv
src/hazard_pkg.sv
src/stage_if.sv
src/stage_reg.sv
src/stall_detector.sv
src/forward_unit.sv
src/hazard_top.sv
bench/hazard_sva.sv
bench/hazard_tb.sv

//--- Bender.yml
package:
  name: hazard_ctrl

sources:
  # packages first, then the RTL in dependency order
  - src/rv_isa_pkg.sv
  - src/hazard_pkg.sv
  - src/stage_if.sv
  - src/stage_reg.sv
  - src/stall_detector.sv
  - src/forward_unit.sv
  - src/hazard_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - bench/hazard_sva.sv
      - bench/hazard_tb.sv
